// File: uart_line_pkg.sv
/*
	uart serial line definitions
	8N1 framing constants, 16x oversample tick divisor, data byte and
	counter types, receiver and transmitter FSM state encodings
*/
`default_nettype none

package uart_line_pkg;

	// bit rate is fixed at build time
	localparam int unsigned CLK_HZ     = 10_000_000;	// system clock
	localparam int unsigned BAUD       = 78_125;	// line rate
	localparam int unsigned OVERSAMPLE = 16;	// ticks per bit time
	localparam int unsigned TICK_DIV   = CLK_HZ / (BAUD * OVERSAMPLE);	// 8 clocks per tick
	localparam int unsigned TICK_W     = $clog2(TICK_DIV);	// divider count width
	localparam int unsigned BYTE_W     = 8;	// data bits per frame

	typedef logic [BYTE_W-1:0] byte_t;	// one data byte
	typedef logic [$clog2(OVERSAMPLE)-1:0] os_cnt_t;	// ticks within a bit
	typedef logic [$clog2(BYTE_W)-1:0] bit_idx_t;	// data bit number

	localparam os_cnt_t OS_LAST = os_cnt_t'(OVERSAMPLE - 1);	// last tick of a bit
	localparam os_cnt_t OS_MID = os_cnt_t'(OVERSAMPLE / 2 - 1);	// middle of start bit
	localparam bit_idx_t BIT_LAST = bit_idx_t'(BYTE_W - 1);	// msb, sent last

	// receiver FSM
	typedef enum logic [1:0] {
		RX_IDLE,	// waiting for a falling edge
		RX_START,	// checking the start bit at mid-bit
		RX_DATA,	// sampling 8 data bits
		RX_STOP		// sampling the stop bit
	} rx_state_t;

	// transmitter FSM
	typedef enum logic [1:0] {
		TX_IDLE,	// line high, clear to send
		TX_START,	// start bit, line low
		TX_DATA,	// data bits lsb first
		TX_STOP		// stop bit, line high
	} tx_state_t;

endpackage

`default_nettype wire

// File: uart_map_pkg.sv
/*
	uart bus map definitions
	word bus request struct, address and data types, the four register
	offsets and the bit positions inside command and status words
*/
`default_nettype none

package uart_map_pkg;

	typedef logic [31:0] addr_t;	// byte address
	typedef logic [31:0] word_t;	// bus data word

	// one bus access, valid only while de is high
	typedef struct packed {
		logic  de;	// access enable
		logic  drw;	// 1 = write, 0 = read
		addr_t daddr;	// register byte address
		word_t din;	// write data
	} bus_req_t;

	// register map, exact decode
	localparam addr_t ADDR_CMD    = 32'h0000_0000;	// command, reads zero
	localparam addr_t ADDR_STATUS = 32'h0000_0004;	// {30'b0, rdy, cts}
	localparam addr_t ADDR_RXBUF  = 32'h0000_0008;	// received byte
	localparam addr_t ADDR_TXBUF  = 32'h0000_000c;	// byte to send

	/*
		command bits act only on the write cycle, so writing 0x3
		starts a send and clears the ready flag together
	*/
	localparam int unsigned CMD_SEND_BIT  = 0;	// start a frame
	localparam int unsigned CMD_CLEAR_BIT = 1;	// drop rdy

	// status bits
	localparam int unsigned ST_CTS_BIT = 0;	// transmitter idle
	localparam int unsigned ST_RDY_BIT = 1;	// new byte waiting

	// unused upper bits of a status or buffer read are zero



endpackage

`default_nettype wire

// File: uart_baud_timer.sv
/*
	uart oversample tick generator
	free-running divider giving a one-clock tick16 pulse every
	TICK_DIV clocks, sixteen ticks per bit time
*/
`timescale 1ns/10ps
`default_nettype none

module uart_baud_timer (
	input  logic clk,
	input  logic rst,
	output logic tick16
);

	import uart_line_pkg::*;

	logic [TICK_W-1:0] cnt;	// clocks since last tick

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt    <= '0;
			tick16 <= 1'b0;
		end else if (cnt == TICK_W'(TICK_DIV - 1)) begin
			cnt    <= '0;	// wrap
			tick16 <= 1'b1;	// one pulse per wrap
		end else begin
			cnt    <= cnt + 1'b1;
			tick16 <= 1'b0;
		end
	end

	// ticks are spaced apart, never back to back
	a_tick_single : assert property (
		@(posedge clk) disable iff (rst)
		tick16 |=> !tick16
	) else $error("tick16 high on two cycles in a row");

endmodule

`default_nettype wire

// File: uart_rx.sv
/*
	uart receiver
	synchronizes rxd, checks the start bit at mid-bit, samples data
	and stop bits every 16 ticks, loads rx_byte and sets rdy on a good
	stop bit, drops the frame on a low one
*/
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  rxd,
	input  logic                  tick16,
	input  logic                  clear,
	output uart_line_pkg::byte_t  rx_byte,
	output logic                  rdy
);

	import uart_line_pkg::*;

	logic [2:0] sync;	// [0],[1] synchronizer, [2] previous level
	logic       rxd_s;	// synchronized line
	logic       fall;	// high to low on the synced line
	rx_state_t  state;
	os_cnt_t    sub;	// ticks within the current bit
	bit_idx_t   idx;	// data bit being sampled
	byte_t      shreg;	// incoming bits, lsb first

	assign rxd_s = sync[1];
	assign fall  = sync[2] & ~sync[1];	// edge, so a held-low line is not a new start

	always_ff @(posedge clk) begin
		if (rst) begin
			sync <= '1;	// idle line is high
		end else begin
			sync <= {sync[1:0], rxd};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= RX_IDLE;
			sub     <= '0;
			idx     <= '0;
			rx_byte <= '0;
			rdy     <= 1'b0;
		end else begin
			if (clear)
				rdy <= 1'b0;	// a frame finishing below still wins
			case (state)
				RX_IDLE: begin
					sub <= '0;
					if (fall)
						state <= RX_START;
				end
				RX_START: if (tick16) begin
					sub <= sub + 1'b1;
					if (sub == OS_MID) begin	// mid start bit
						sub <= '0;
						idx <= '0;
						state <= rxd_s ? RX_IDLE : RX_DATA;	// high again = glitch
					end
				end
				RX_DATA: if (tick16) begin
					sub <= sub + 1'b1;	// wraps to 0 after OS_LAST
					if (sub == OS_LAST) begin	// mid data bit
						shreg <= {rxd_s, shreg[BYTE_W-1:1]};	// lsb arrives first
						idx   <= idx + 1'b1;
						if (idx == BIT_LAST)
							state <= RX_STOP;
					end
				end
				RX_STOP: if (tick16) begin
					sub <= sub + 1'b1;
					if (sub == OS_LAST) begin	// mid stop bit
						state <= RX_IDLE;
						if (rxd_s) begin	// good frame
							rx_byte <= shreg;	// overwrites an unread byte
							rdy     <= 1'b1;
						end
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// rdy only rises when a frame completes out of RX_STOP
	a_rdy_from_stop : assert property (
		@(posedge clk) disable iff (rst)
		$rose(rdy) |-> ($past(state) == RX_STOP && state == RX_IDLE)
	) else $error("rdy rose outside the end of a frame");

endmodule

`default_nettype wire

// File: uart_tx.sv
/*
	uart transmitter
	copies tx_byte on send, then drives start, 8 data bits lsb first and
	stop, each 16 ticks long, through a registered txd; cts while idle
*/
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  tick16,
	input  logic                  send,
	input  uart_line_pkg::byte_t  tx_byte,
	output logic                  txd,
	output logic                  cts
);

	import uart_line_pkg::*;

	tx_state_t state;
	os_cnt_t   sub;	// ticks within the current bit
	bit_idx_t  idx;	// data bit on the line
	byte_t     shreg;	// byte being sent, shifted right

	assign cts = (state == TX_IDLE);	// send while busy is dropped

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= TX_IDLE;
			sub   <= '0;
			idx   <= '0;
			txd   <= 1'b1;	// line idles high
		end else begin
			case (state)
				TX_IDLE: begin
					txd <= 1'b1;
					if (send) begin
						shreg <= tx_byte;	// copy at frame start
						sub   <= '0;	// bit phase starts here
						idx   <= '0;
						txd   <= 1'b0;	// start bit from next edge
						state <= TX_START;
					end
				end
				TX_START: if (tick16) begin
					sub <= sub + 1'b1;
					if (sub == OS_LAST) begin
						txd   <= shreg[0];	// first data bit
						state <= TX_DATA;
					end
				end
				TX_DATA: if (tick16) begin
					sub <= sub + 1'b1;
					if (sub == OS_LAST) begin
						idx   <= idx + 1'b1;
						shreg <= shreg >> 1;
						if (idx == BIT_LAST) begin
							txd   <= 1'b1;	// stop bit
							state <= TX_STOP;
						end else begin
							txd <= shreg[1];	// next bit up
						end
					end
				end
				TX_STOP: if (tick16) begin
					sub <= sub + 1'b1;
					if (sub == OS_LAST)
						state <= TX_IDLE;	// cts back on
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	a_idle_high : assert property (
		@(posedge clk) disable iff (rst)
		state == TX_IDLE |-> txd
	) else $error("txd low while transmitter idle");

	a_start_on_send : assert property (
		@(posedge clk) disable iff (rst)
		(state == TX_IDLE && !send) |=> state == TX_IDLE
	) else $error("frame started without send");

endmodule

`default_nettype wire

// File: uart_regs.sv
/*
	uart bus registers
	exact address decode, send buffer, send and clear command strobes
	and the combinational read mux for the four-word map
*/
`timescale 1ns/10ps
`default_nettype none

module uart_regs (
	input  logic                   clk,
	input  logic                   rst,
	input  uart_map_pkg::bus_req_t bus_req,
	output uart_map_pkg::word_t    dout,
	output logic                   send,
	output logic                   clear,
	output uart_line_pkg::byte_t   tx_byte,
	input  uart_line_pkg::byte_t   rx_byte,
	input  logic                   rdy,
	input  logic                   cts
);

	import uart_map_pkg::*;
	import uart_line_pkg::*;

	logic  wr;	// write access this cycle
	logic  cmd_wr;	// write to the command register
	word_t rd_data;	// selected register, before de gating

	assign wr     = bus_req.de & bus_req.drw;
	assign cmd_wr = wr && (bus_req.daddr == ADDR_CMD);

	// strobes live for the write cycle only
	assign send  = cmd_wr & bus_req.din[CMD_SEND_BIT];	// busy check is in tx
	assign clear = cmd_wr & bus_req.din[CMD_CLEAR_BIT];

	// send buffer
	always_ff @(posedge clk) begin
		if (rst) begin
			tx_byte <= '0;
		end else if (wr && bus_req.daddr == ADDR_TXBUF) begin
			tx_byte <= byte_t'(bus_req.din);	// low byte only
		end
	end

	always_comb begin
		rd_data = '0;	// command reg and holes read zero
		case (bus_req.daddr)
			ADDR_STATUS: begin
				rd_data[ST_RDY_BIT] = rdy;
				rd_data[ST_CTS_BIT] = cts;
			end
			ADDR_RXBUF: rd_data = word_t'(rx_byte);	// zero-extended
			ADDR_TXBUF: rd_data = word_t'(tx_byte);
			default:    rd_data = '0;
		endcase
	end

	assign dout = bus_req.de ? rd_data : '0;	// quiet bus when not selected

	// strobes come from a command write and carry its data bits
	a_strobe_src : assert property (
		@(posedge clk) disable iff (rst)
		(send || clear) |-> (bus_req.de && bus_req.drw && bus_req.daddr == ADDR_CMD)
	) else $error("send or clear outside a command write");

endmodule

`default_nettype wire

// File: uart_top.sv
/*
	memory-mapped uart, 8N1 with 16x oversampled receive
	ties the tick generator, receiver, transmitter and bus registers
*/
`timescale 1ns/10ps
`default_nettype none

module uart_top (
	input  logic                   clk,
	input  logic                   rst,
	input  uart_map_pkg::bus_req_t bus_req,
	output uart_map_pkg::word_t    dout,
	input  logic                   rxd,
	output logic                   txd
);

	import uart_line_pkg::*;

	logic  tick16;	// 1/16 bit time pulse
	logic  send;	// command strobe to tx
	logic  clear;	// command strobe to rx
	logic  rdy;	// byte waiting
	logic  cts;	// tx idle
	byte_t tx_byte;	// send buffer
	byte_t rx_byte;	// last good received byte

	uart_baud_timer u_baud (
		.clk    (clk),
		.rst    (rst),
		.tick16 (tick16)
	);

	uart_rx u_rx (
		.clk     (clk),
		.rst     (rst),
		.rxd     (rxd),
		.tick16  (tick16),
		.clear   (clear),
		.rx_byte (rx_byte),
		.rdy     (rdy)
	);

	uart_tx u_tx (
		.clk     (clk),
		.rst     (rst),
		.tick16  (tick16),
		.send    (send),
		.tx_byte (tx_byte),
		.txd     (txd),
		.cts     (cts)
	);

	uart_regs u_regs (
		.clk     (clk),
		.rst     (rst),
		.bus_req (bus_req),
		.dout    (dout),
		.send    (send),
		.clear   (clear),
		.tx_byte (tx_byte),
		.rx_byte (rx_byte),
		.rdy     (rdy),
		.cts     (cts)
	);

endmodule

`default_nettype wire

// File: tb_uart_top.sv
/*
	uart testbench
	drives the word bus and the rxd line, rebuilds frames seen on txd
	and checks reset values, register readback, transmit, busy send,
	receive, clear and framing error handling
*/
`timescale 1ns/10ps
`default_nettype none

module tb_uart_top;

	import uart_line_pkg::*;
	import uart_map_pkg::*;

	localparam int BIT_CLKS       = TICK_DIV * OVERSAMPLE;	// 128 clocks per bit
	localparam int FRAME_CLKS     = 10 * BIT_CLKS;	// start, 8 data, stop
	localparam int TIMEOUT_CYCLES = 20_000;	// about eight frames plus margin

	logic     clk;
	logic     rst;
	logic     rxd;
	logic     txd;
	bus_req_t bus_req;
	word_t    dout;
	logic     line_quiet;	// txd must stay high while set
	int       cycle = 0;	// clocks since time zero
	integer   seed = 32'he8279fcd;

	uart_top u_dut (
		.clk     (clk),
		.rst     (rst),
		.bus_req (bus_req),
		.dout    (dout),
		.rxd     (rxd),
		.txd     (txd)
	);

	always #50 clk = ~clk;	// 100 ns period

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic expect_word(input string name, input word_t exp, input word_t act);
		assert (act === exp) else
			fail_stop($sformatf("Fail %s expected 0x%08h actual 0x%08h", name, exp, act));
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES)
			fail_stop("run reached the cycle limit without finishing");
	end

	function automatic bus_req_t pack_req(input logic de, input logic drw,
			input addr_t addr, input word_t data);
		bus_req_t req;
		req.de    = de;
		req.drw   = drw;
		req.daddr = addr;
		req.din   = data;
		return req;
	endfunction

	// one write strobe, taken by the DUT on the second edge
	task automatic bus_write(input addr_t addr, input word_t data);
		@(posedge clk);
		bus_req <= pack_req(1'b1, 1'b1, addr, data);
		@(posedge clk);
		bus_req <= pack_req(1'b0, 1'b0, '0, '0);
	endtask

	task automatic bus_read(input addr_t addr, output word_t data);
		@(posedge clk);
		bus_req <= pack_req(1'b1, 1'b0, addr, '0);
		@(negedge clk);
		data = dout;	// combinational, settled mid-cycle
		@(posedge clk);
		bus_req <= pack_req(1'b0, 1'b0, '0, '0);
	endtask

	// polls status until a bit reaches a level
	task automatic wait_status(input int bit_pos, input logic level, input int limit,
			input string what);
		int    start;
		word_t st;
		start = cycle;
		bus_read(ADDR_STATUS, st);
		while (st[bit_pos] !== level) begin
			if (cycle - start > limit)
				fail_stop(what);
			bus_read(ADDR_STATUS, st);
		end
	endtask

	// serial source on rxd, lsb first
	task automatic drive_frame(input byte_t data, input logic stop);
		logic [9:0] frame;
		frame = {stop, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			rxd <= frame[i];
			repeat (BIT_CLKS - 1) @(posedge clk);
		end
		@(posedge clk);
		rxd <= 1'b1;	// back to idle
	endtask

	// txd monitor, samples mid-bit from the falling start edge
	task automatic capture_frame(output byte_t data, output logic stop);
		int waited;
		waited = 0;
		@(negedge clk);
		while (txd !== 1'b0) begin
			if (waited > 4 * BIT_CLKS)
				fail_stop("transmit frame did not start on txd");
			waited++;
			@(negedge clk);
		end
		repeat (BIT_CLKS / 2) @(negedge clk);	// middle of start bit
		assert (txd === 1'b0) else fail_stop("start bit on txd ended too early");
		for (int i = 0; i < 8; i++) begin
			repeat (BIT_CLKS) @(negedge clk);
			data[i] = txd;
		end
		repeat (BIT_CLKS) @(negedge clk);
		stop = txd;
	endtask

	a_dout_quiet : assert property (
		@(posedge clk) disable iff (rst)
		!bus_req.de |-> dout == '0
	) else fail_stop("dout not zero while de is low");

	a_line_quiet : assert property (
		@(posedge clk) disable iff (rst)
		line_quiet |-> txd
	) else fail_stop("a second frame started on txd after a busy send");

	initial begin
		word_t rd;
		word_t wr_word;
		byte_t tx_val;
		byte_t busy_val;
		byte_t rx_val;
		byte_t rx_next;
		byte_t bad_val;
		byte_t got;
		logic  stop;
		int    sent_at;
		int    waited;
		clk        = 1'b0;
		rst        = 1'b1;
		rxd        = 1'b1;	// idle line
		line_quiet = 1'b0;
		bus_req    = pack_req(1'b0, 1'b0, '0, '0);
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		// reset values
		@(negedge clk);
		expect_word("reset_txd", 32'h1, {31'h0, txd});
		bus_read(ADDR_STATUS, rd);
		expect_word("reset_status", 32'h1, rd);	// cts set, rdy clear
		bus_read(ADDR_CMD, rd);
		expect_word("reset_cmd", 32'h0, rd);
		@(posedge clk);
		bus_req <= pack_req(1'b0, 1'b0, ADDR_STATUS, '0);
		@(negedge clk);
		expect_word("idle_dout", 32'h0, dout);

		// register readback
		wr_word = $random(seed);
		tx_val  = wr_word[7:0];
		bus_write(ADDR_TXBUF, wr_word);	// upper bits must be dropped
		bus_read(ADDR_TXBUF, rd);
		expect_word("txbuf_readback", {24'h0, tx_val}, rd);
		bus_read(32'h10, rd);
		expect_word("unmapped_read", 32'h0, rd);

		// transmit one frame
		fork
			capture_frame(got, stop);
			begin
				bus_write(ADDR_CMD, 32'h1);
				sent_at = cycle;
				@(negedge clk);
				expect_word("tx_start_bit", 32'h0, {31'h0, txd});
				bus_read(ADDR_STATUS, rd);
				expect_word("tx_busy_cts", 32'h0, rd & 32'h1);
			end
		join
		expect_word("tx_data", {24'h0, tx_val}, {24'h0, got});
		expect_word("tx_stop", 32'h1, {31'h0, stop});
		bus_read(ADDR_STATUS, rd);
		expect_word("tx_cts_in_stop", 32'h0, rd & 32'h1);
		wait_status(ST_CTS_BIT, 1'b1, FRAME_CLKS, "cts never rose after the frame");
		waited = cycle - sent_at;
		assert (waited >= FRAME_CLKS - 2 * TICK_DIV && waited <= FRAME_CLKS + 2 * TICK_DIV)
			else fail_stop("cts did not return about one frame time after send");

		// send while busy is ignored
		busy_val = byte_t'($random(seed));
		bus_write(ADDR_TXBUF, {24'h0, busy_val});
		fork
			capture_frame(got, stop);
			begin
				bus_write(ADDR_CMD, 32'h1);
				repeat (3 * BIT_CLKS) @(posedge clk);	// into the data bits
				bus_write(ADDR_TXBUF, {24'h0, ~busy_val});
				bus_write(ADDR_CMD, 32'h1);
			end
		join
		expect_word("busy_data", {24'h0, busy_val}, {24'h0, got});
		expect_word("busy_stop", 32'h1, {31'h0, stop});
		wait_status(ST_CTS_BIT, 1'b1, FRAME_CLKS, "cts never rose after the busy frame");
		line_quiet <= 1'b1;
		repeat (2 * BIT_CLKS) @(posedge clk);
		line_quiet <= 1'b0;
		bus_read(ADDR_STATUS, rd);
		expect_word("busy_no_second", 32'h1, rd);

		// receive, then clear
		rx_val = byte_t'($random(seed));
		fork
			drive_frame(rx_val, 1'b1);
			wait_status(ST_RDY_BIT, 1'b1, FRAME_CLKS, "rdy never rose within 10 bit times");
		join
		bus_read(ADDR_RXBUF, rd);
		expect_word("rx_data", {24'h0, rx_val}, rd);
		bus_write(ADDR_CMD, 32'h2);
		bus_read(ADDR_STATUS, rd);
		expect_word("rx_clear", 32'h1, rd);

		// send and clear in one command
		rx_next = byte_t'($random(seed));
		fork
			drive_frame(rx_next, 1'b1);
			wait_status(ST_RDY_BIT, 1'b1, FRAME_CLKS, "rdy never rose for the second byte");
		join
		bus_read(ADDR_RXBUF, rd);
		expect_word("rx_data_next", {24'h0, rx_next}, rd);
		fork
			capture_frame(got, stop);
			begin
				bus_write(ADDR_CMD, 32'h3);
				bus_read(ADDR_STATUS, rd);
				expect_word("send_clear_status", 32'h0, rd);	// busy, rdy dropped
			end
		join
		expect_word("send_clear_data", {24'h0, ~busy_val}, {24'h0, got});
		wait_status(ST_CTS_BIT, 1'b1, FRAME_CLKS, "cts never rose after the send-clear frame");

		// low stop bit drops the frame
		bad_val = byte_t'($random(seed));
		drive_frame(bad_val, 1'b0);
		repeat (BIT_CLKS) @(posedge clk);	// past the point rdy would rise
		bus_read(ADDR_STATUS, rd);
		expect_word("frame_err_status", 32'h1, rd);
		bus_read(ADDR_RXBUF, rd);
		expect_word("frame_err_rxbuf", {24'h0, rx_next}, rd);

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
uart_line_pkg.sv
uart_map_pkg.sv
uart_baud_timer.sv
uart_rx.sv
uart_tx.sv
uart_regs.sv
uart_top.sv
tb_uart_top.sv

// File: Bender.yml
package:
  name: uart_top

sources:
  - uart_line_pkg.sv
  - uart_map_pkg.sv
  - uart_baud_timer.sv
  - uart_rx.sv
  - uart_tx.sv
  - uart_regs.sv
  - uart_top.sv
  - target: test
    files:
      - tb_uart_top.sv
